// File: sim.f
verilog/blackjack_pkg.sv
verilog/card_lfsr.sv
verilog/card_source.sv
verilog/hand_scorer.sv
verilog/game_fsm.sv
verilog/blackjack_core.sv
testbench/bj_checker.sv
testbench/tb_blackjack.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the blackjack testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_blackjack -f sim.f -o tb_blackjack
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_blackjack > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0

// File: testbench/tb_blackjack.sv
// testbench top; seeded random player actions, one tick every 4 clocks, runs a fixed number of rounds
`timescale 1ns/1ns

module tb_blackjack import blackjack_pkg::*; ();

    localparam int          CLK_PERIOD  = 40;
    localparam int          TICK_CLKS   = 4;
    localparam int          NUM_ROUNDS  = 200;
    localparam int          ROUND_TICKS = 40;   // generous bound for one round
    localparam int          WATCHDOG_NS = NUM_ROUNDS * ROUND_TICKS * TICK_CLKS * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'hf5af_cb9a;

    logic        clk      = 1'b0;
    logic        rst      = 1'b1;
    logic        tick     = 1'b0;
    logic        deal     = 1'b0;
    logic        hit      = 1'b0;
    logic        stand    = 1'b0;
    logic        ack      = 1'b0;
    logic [1:0]  tick_cnt = 2'd0;
    hand_t       player_hand, dealer_hand;
    total_t      player_total, dealer_total;
    status_t     status;
    int          errors, checks, rounds;

    always #(CLK_PERIOD / 2) clk = ~clk;

    //----------------------------------------------------------------------
    // stimulus, new levels every clock
    //----------------------------------------------------------------------
    initial begin : drive_inputs
        int unsigned act;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            act = $urandom % 4; // 0 hit, 1 stand, else wait
            if (rst) begin
                tick     <= 1'b0;
                tick_cnt <= 2'd0;
            end else begin
                tick_cnt <= tick_cnt + 2'd1;
                tick     <= (tick_cnt == 2'd3);
                deal     <= ($urandom % 2) == 0;
                hit      <= (act == 0) && (int'(player_hand.count) < MAX_CARDS); // no hit on a full hand
                stand    <= (act == 1);
                ack      <= ($urandom % 2) == 0;
            end
        end
    end

    blackjack_core blackjack_core_inst (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .deal         (deal),
        .hit          (hit),
        .stand        (stand),
        .ack          (ack),
        .player_hand  (player_hand),
        .dealer_hand  (dealer_hand),
        .player_total (player_total),
        .dealer_total (dealer_total),
        .status       (status)
    );

    bj_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .tick         (tick),
        .deal         (deal),
        .hit          (hit),
        .stand        (stand),
        .ack          (ack),
        .player_hand  (player_hand),
        .dealer_hand  (dealer_hand),
        .player_total (player_total),
        .dealer_total (dealer_total),
        .status       (status),
        .errors       (errors),
        .checks       (checks),
        .rounds       (rounds)
    );

    initial begin : run_rounds
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (rounds < NUM_ROUNDS) begin
            @(posedge clk);
        end
        repeat (TICK_CLKS) @(posedge clk);
        $display("rounds %0d  checks %0d  errors %0d", rounds, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d of %0d rounds finished, the game looks stuck",
                 WATCHDOG_NS, rounds, NUM_ROUNDS);
        $display("rounds %0d  checks %0d  errors %0d", rounds, checks, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: testbench/bj_checker.sv
// samples the DUT at the falling clock edge; assumes hit and stand are never high together
`timescale 1ns/1ns

module bj_checker import blackjack_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  logic    deal,
    input  logic    hit,
    input  logic    stand,
    input  logic    ack,
    input  hand_t   player_hand,
    input  hand_t   dealer_hand,
    input  total_t  player_total,
    input  total_t  dealer_total,
    input  status_t status,
    output int      errors,
    output int      checks,
    output int      rounds
);

    int      err_cnt = 0;
    int      chk_cnt = 0;
    int      rnd_cnt = 0;
    logic    pend = 1'b0;       // tick seen in the last clock
    status_t s_status;          // snapshot from the tick clock
    int      s_pc, s_dc, s_pt, s_dt;
    logic    s_deal, s_hit, s_stand, s_ack;
    int      deal_step = 4;     // below 4 while the deal is running
    logic    pchk = 1'b0;       // hit waiting for its bust check
    logic    cmp = 1'b0;        // dealer stood, compare next
    result_t exp_res = NONE;

    assign errors = err_cnt;
    assign checks = chk_cnt;
    assign rounds = rnd_cnt;

    //----------------------------------------------------------------------
    // rule model and reporting
    //----------------------------------------------------------------------
    function automatic int model_total(input hand_t h);
        int   sum;
        logic ace;
        sum = 0;
        ace = 1'b0;
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (i < int'(h.count)) begin
                sum += (h.cards[i] > 4'd10) ? 10 : int'(h.cards[i]); // faces count 10
                ace |= (h.cards[i] == 4'd1);
            end
        end
        return (ace && sum <= 11) ? sum + 10 : sum;
    endfunction

    task automatic report_value(input string name, input int exp_v, input int act_v);
        chk_cnt++;
        if (exp_v != act_v) begin
            $display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("t=%0t %s", $time, msg);
        err_cnt++;
    endtask

    task automatic check_hand(input hand_t h, input total_t t, input string who);
        for (int i = 0; i < MAX_CARDS; i++) begin
            if (i < int'(h.count)) begin
                chk_cnt++;
                if (h.cards[i] == 4'd0 || h.cards[i] > 4'd13)
                    report_error($sformatf("%s hand slot %0d holds no valid rank (%0d)",
                                           who, i, h.cards[i]));
            end else begin
                report_value($sformatf("%s_hand.cards[%0d]", who, i), 0, int'(h.cards[i]));
            end
        end
        report_value({who, "_total"}, model_total(h), int'(t));
    endtask

    //----------------------------------------------------------------------
    // game flow, one step per tick
    //----------------------------------------------------------------------
    task automatic check_step();
        phase_t exp_ph;
        int     exp_pc;
        int     exp_dc;
        exp_ph = s_status.phase;
        exp_pc = s_pc;
        exp_dc = s_dc;
        case (s_status.phase)
            IDLE_PH: begin
                if (s_deal) begin
                    exp_ph    = PLAYER_PH;
                    deal_step = 0;
                    pchk      = 1'b0;
                    cmp       = 1'b0;
                end
            end
            PLAYER_PH: begin
                if (deal_step < 4) begin // clear, two player cards, dealer card
                    deal_step++;
                    exp_pc = (deal_step == 1) ? 0 : ((deal_step == 2) ? 1 : 2);
                    exp_dc = (deal_step == 4) ? 1 : 0;
                end else if (pchk) begin
                    pchk = 1'b0;
                    if (s_pt > int'(BUST_LIMIT)) exp_ph = DONE_PH;
                end else if (s_hit) begin
                    exp_pc = (s_pc < MAX_CARDS) ? s_pc + 1 : s_pc;
                    pchk   = 1'b1;
                end else if (s_stand) begin
                    exp_ph = DEALER_PH;
                end
            end
            DEALER_PH: begin
                if (cmp || s_dt > int'(BUST_LIMIT)) begin
                    exp_ph = DONE_PH;
                end else if (s_dt >= int'(DEALER_STAND)) begin
                    cmp = 1'b1;
                end else begin
                    exp_dc = s_dc + 1; // dealer draws
                end
            end
            default: begin
                if (s_ack) exp_ph = IDLE_PH;
            end
        endcase
        report_value("status.phase", int'(exp_ph), int'(status.phase));
        report_value("player_hand.count", exp_pc, int'(player_hand.count));
        report_value("dealer_hand.count", exp_dc, int'(dealer_hand.count));
    endtask

    task automatic end_round();
        int pt;
        int dt;
        pt = model_total(player_hand);
        dt = model_total(dealer_hand);
        rnd_cnt++;
        if (pt <= int'(BUST_LIMIT) && dt < int'(DEALER_STAND))
            report_error("round ended with the dealer below 17 and no player bust");
        if (pt > int'(BUST_LIMIT)) exp_res = DEALER_WINS;
        else if (dt > int'(BUST_LIMIT)) exp_res = PLAYER_WINS;
        else if (pt > dt) exp_res = PLAYER_WINS;
        else if (dt > pt) exp_res = DEALER_WINS;
        else exp_res = PUSH;
    endtask

    always @(negedge clk) begin
        check_hand(player_hand, player_total, "player");
        check_hand(dealer_hand, dealer_total, "dealer");
        if (rst) begin
            pend    = 1'b0;
            exp_res = NONE;
            report_value("status.phase", int'(IDLE_PH), int'(status.phase));
        end else if (pend) begin
            check_step();
            if (status.phase == DONE_PH && s_status.phase != DONE_PH) end_round();
        end
        if (status.phase == DONE_PH && !rst) begin
            report_value("status.result", int'(exp_res), int'(status.result));
        end else begin
            report_value("status.result", int'(NONE), int'(status.result));
        end
        pend     = tick && !rst;
        s_status = status;
        s_pc     = int'(player_hand.count);
        s_dc     = int'(dealer_hand.count);
        s_pt     = model_total(player_hand);
        s_dt     = model_total(dealer_hand);
        s_deal   = deal;
        s_hit    = hit;
        s_stand  = stand;
        s_ack    = ack;
    end

endmodule

// File: verilog/blackjack_core.sv
// blackjack rule engine top; tick comes from outside, at most one every 4 clocks
`timescale 1ns/1ns

module blackjack_core import blackjack_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  logic    deal,
    input  logic    hit,
    input  logic    stand,
    input  logic    ack,
    output hand_t   player_hand,
    output hand_t   dealer_hand,
    output total_t  player_total,
    output total_t  dealer_total,
    output status_t status
);

    card_t  card0;
    card_t  card1;
    card_t  card2;
    logic   hand_clear;
    logic   append    [NUM_HANDS];
    card_t  hand_card [NUM_HANDS];
    hand_t  hands     [NUM_HANDS];
    total_t totals    [NUM_HANDS];

    card_source u_card_source (
        .clk   (clk),
        .rst   (rst),
        .card0 (card0),
        .card1 (card1),
        .card2 (card2)
    );

    //--------------------------------------------------------------------
    // scorers, player then dealer
    //--------------------------------------------------------------------
    genvar g;
    generate
        for (g = 0; g < NUM_HANDS; g++) begin : gen_scorer
            hand_scorer u_hand_scorer (
                .clk    (clk),
                .rst    (rst),
                .clear  (hand_clear),
                .append (append[g]),
                .card   (hand_card[g]),
                .hand   (hands[g]),
                .total  (totals[g])
            );
        end
    endgenerate

    game_fsm u_game_fsm (
        .clk           (clk),
        .rst           (rst),
        .tick          (tick),
        .deal          (deal),
        .hit           (hit),
        .stand         (stand),
        .ack           (ack),
        .card0         (card0),
        .card1         (card1),
        .card2         (card2),
        .player_total  (totals[PLAYER_IDX]),
        .dealer_total  (totals[DEALER_IDX]),
        .player_append (append[PLAYER_IDX]),
        .dealer_append (append[DEALER_IDX]),
        .hand_clear    (hand_clear),
        .player_card   (hand_card[PLAYER_IDX]),
        .dealer_card   (hand_card[DEALER_IDX]),
        .status        (status)
    );

    assign player_hand  = hands[PLAYER_IDX];
    assign dealer_hand  = hands[DEALER_IDX];
    assign player_total = totals[PLAYER_IDX];
    assign dealer_total = totals[DEALER_IDX];

endmodule

// File: verilog/game_fsm.sv
// table FSM stepped by tick; inputs are levels sampled only on tick, ticks must be at least 2 clocks apart
`timescale 1ns/1ns

module game_fsm import blackjack_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    tick,
    input  logic    deal,
    input  logic    hit,
    input  logic    stand,
    input  logic    ack,
    input  card_t   card0,
    input  card_t   card1,
    input  card_t   card2,
    input  total_t  player_total,
    input  total_t  dealer_total,
    output logic    player_append,
    output logic    dealer_append,
    output logic    hand_clear,
    output card_t   player_card,
    output card_t   dealer_card,
    output status_t status
);

    //--------------------------------------------------------------------
    // state encoding
    //--------------------------------------------------------------------
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        DEAL_CLR     = 4'd1,
        DEAL_P0      = 4'd2, // first player card
        DEAL_P1      = 4'd3, // second player card
        DEAL_D0      = 4'd4, // dealer up card
        PLAYER_TURN  = 4'd5,
        PLAYER_CHECK = 4'd6,
        DEALER_CHECK = 4'd7,
        COMPARE      = 4'd8,
        DONE         = 4'd9
    } state_t;

    state_t  state;
    state_t  state_nxt;
    result_t result;
    result_t result_nxt;

    //--------------------------------------------------------------------
    // state and result registers
    //--------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= IDLE;
            result <= NONE;
        end else begin
            state  <= state_nxt;
            result <= result_nxt;
        end
    end

    //--------------------------------------------------------------------
    // next state and scorer strobes, all gated by tick
    //--------------------------------------------------------------------
    always_comb begin
        state_nxt     = state;
        result_nxt    = result;
        player_append = 1'b0;
        dealer_append = 1'b0;
        hand_clear    = 1'b0;
        if (tick) begin
            case (state)
                IDLE: begin
                    if (deal) begin
                        state_nxt = DEAL_CLR;
                    end
                end
                DEAL_CLR: begin
                    hand_clear = 1'b1; // both hands emptied together
                    state_nxt  = DEAL_P0;
                end
                DEAL_P0: begin
                    player_append = 1'b1;
                    state_nxt     = DEAL_P1;
                end
                DEAL_P1: begin
                    player_append = 1'b1;
                    state_nxt     = DEAL_D0;
                end
                DEAL_D0: begin
                    dealer_append = 1'b1;
                    state_nxt     = PLAYER_TURN;
                end
                PLAYER_TURN: begin
                    if (hit) begin // hit wins over stand
                        player_append = 1'b1;
                        state_nxt     = PLAYER_CHECK;
                    end else if (stand) begin
                        state_nxt = DEALER_CHECK;
                    end
                end
                PLAYER_CHECK: begin
                    if (player_total > BUST_LIMIT) begin
                        result_nxt = DEALER_WINS;
                        state_nxt  = DONE;
                    end else begin
                        state_nxt = PLAYER_TURN;
                    end
                end
                DEALER_CHECK: begin
                    if (dealer_total > BUST_LIMIT) begin
                        result_nxt = PLAYER_WINS;
                        state_nxt  = DONE;
                    end else if (dealer_total >= DEALER_STAND) begin
                        state_nxt = COMPARE;
                    end else begin
                        dealer_append = 1'b1; // draw, total rechecked next tick
                    end
                end
                COMPARE: begin
                    if (player_total > dealer_total) begin
                        result_nxt = PLAYER_WINS;
                    end else if (dealer_total > player_total) begin
                        result_nxt = DEALER_WINS;
                    end else begin
                        result_nxt = PUSH;
                    end
                    state_nxt = DONE;
                end
                DONE: begin
                    if (ack) begin
                        result_nxt = NONE;
                        state_nxt  = IDLE;
                    end
                end
                default: begin
                    state_nxt = IDLE;
                end
            endcase
        end
    end

    // card routing
    assign player_card = (state == DEAL_P1) ? card1 : card0;
    assign dealer_card = (state == DEAL_D0) ? card2 : card0;

    //--------------------------------------------------------------------
    // status, Moore on the registers
    //--------------------------------------------------------------------
    always_comb begin
        case (state)
            IDLE:                  status.phase = IDLE_PH;
            DEALER_CHECK, COMPARE: status.phase = DEALER_PH;
            DONE:                  status.phase = DONE_PH;
            default:               status.phase = PLAYER_PH; // deal and player turn
        endcase
        status.result = result;
    end

    // a scorer total needs one clock to settle before the next decision
    tick_spacing: assert property (
        @(posedge clk) disable iff (rst) tick |=> !tick
    ) else $error("game_fsm tick in two consecutive clocks");

endmodule

// File: verilog/hand_scorer.sv
// one hand with ace promotion; appends past MAX_CARDS are dropped, total valid 1 clock after append or clear
`timescale 1ns/1ns

module hand_scorer import blackjack_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   clear,
    input  logic   append,
    input  card_t  card,
    output hand_t  hand,
    output total_t total
);

    total_t hard;    // every ace counted as 1
    logic   has_ace;

    // blackjack point value of one rank
    function automatic total_t card_points(input card_t c);
        total_t pts;
        if (c > FACE_RANK_MAX) begin
            pts = FACE_POINTS;
        end else begin
            pts = {1'b0, c};
        end
        return pts;
    endfunction

    //--------------------------------------------------------------------
    // hand storage and hard sum
    //--------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            hand    <= '0;
            hard    <= '0;
            has_ace <= 1'b0;
        end else if (append && (hand.count < MAX_CARDS)) begin
            hand.cards[hand.count] <= card;
            hand.count             <= hand.count + 4'd1;
            hard                   <= hard + card_points(card);
            has_ace                <= has_ace | (card == ACE_RANK);
        end
    end

    // one ace may count 11 while it does not bust the hand
    assign total = (has_ace && (hard <= SOFT_LIMIT)) ? hard + ACE_BONUS : hard;

    //--------------------------------------------------------------------
    // checks on the FSM side
    //--------------------------------------------------------------------
    no_append_full: assert property (
        @(posedge clk) disable iff (rst) append |-> (hand.count < MAX_CARDS)
    ) else $error("hand_scorer append on a full hand");

    no_append_clear: assert property (
        @(posedge clk) disable iff (rst) !(append && clear)
    ) else $error("hand_scorer append and clear in the same clock");

endmodule

// File: verilog/card_source.sv
// three independent card ranks, new every clock; the modulo mapping is slightly biased toward low ranks
`timescale 1ns/1ns

module card_source import blackjack_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output card_t card0,
    output card_t card1,
    output card_t card2
);

    logic [LFSR_W-1:0] lane_state [NUM_LANES];
    card_t             rank       [NUM_LANES];

    //--------------------------------------------------------------------
    // lanes and rank mapping
    //--------------------------------------------------------------------
    genvar g;
    generate
        for (g = 0; g < NUM_LANES; g++) begin : gen_lane
            logic [3:0] nib; // low nibble of the lane

            card_lfsr u_card_lfsr (
                .clk   (clk),
                .rst   (rst),
                .lane  (LANE_W'(g)),
                .state (lane_state[g])
            );

            assign nib = lane_state[g][3:0];

            // nibble mod 13, then shifted to 1..13
            always_comb begin
                if (nib >= CARD_RANKS) begin
                    rank[g] = nib - CARD_RANKS + 4'd1;
                end else begin
                    rank[g] = nib + 4'd1;
                end
            end
        end
    endgenerate

    assign card0 = rank[0];
    assign card1 = rank[1];
    assign card2 = rank[2];

endmodule

// File: verilog/card_lfsr.sv
// free-running 13-bit LFSR lane; lane must be below NUM_LANES and stay constant while running
`timescale 1ns/1ns

module card_lfsr import blackjack_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [LANE_W-1:0] lane,  // instance index, picks the seed
    output logic [LFSR_W-1:0] state
);

    logic feedback;

    // taps 13,4,3,1 give the full 8191 cycle
    assign feedback = state[12] ^ state[3] ^ state[2] ^ state[0];

    //--------------------------------------------------------------------
    // shift register
    //--------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LFSR_SEEDS[lane];
        end else begin
            state <= {state[LFSR_W-2:0], feedback}; // shift left, new bit 0
        end
    end

    // an all-zero state would lock the lane on one rank forever
    lfsr_never_zero: assert property (
        @(posedge clk) disable iff (rst) state != '0
    ) else $error("card_lfsr lane %0d stuck at zero", lane);

endmodule

// File: verilog/blackjack_pkg.sv
// shared types and rule constants; a hand holds at most MAX_CARDS cards and totals saturate at 31
package blackjack_pkg;

    //--------------------------------------------------------------------
    // card and hand
    //--------------------------------------------------------------------
    typedef logic [3:0] card_t; // rank 1..13, 0 is an empty slot

    localparam int MAX_CARDS = 9;
    localparam int COUNT_W   = 4;

    typedef struct packed {
        card_t [MAX_CARDS-1:0] cards; // slot 0 holds the first card
        logic  [COUNT_W-1:0]   count;
    } hand_t;

    typedef logic [4:0] total_t; // largest reachable total is 31

    localparam card_t  CARD_RANKS    = 4'd13;
    localparam card_t  ACE_RANK      = 4'd1;
    localparam card_t  FACE_RANK_MAX = 4'd10; // J, Q, K rank above this
    localparam total_t FACE_POINTS   = 5'd10;
    localparam total_t ACE_BONUS     = 5'd10;
    localparam total_t SOFT_LIMIT    = 5'd11; // ace promoted up to this hard total

    //--------------------------------------------------------------------
    // game rules
    //--------------------------------------------------------------------
    localparam total_t BUST_LIMIT   = 5'd21;
    localparam total_t DEALER_STAND = 5'd17;

    localparam int NUM_HANDS  = 2;
    localparam int PLAYER_IDX = 0;
    localparam int DEALER_IDX = 1;

    typedef enum logic [1:0] {
        IDLE_PH   = 2'd0,
        PLAYER_PH = 2'd1,
        DEALER_PH = 2'd2,
        DONE_PH   = 2'd3
    } phase_t;

    typedef enum logic [1:0] {
        NONE        = 2'd0,
        PLAYER_WINS = 2'd1,
        DEALER_WINS = 2'd2,
        PUSH        = 2'd3
    } result_t;

    typedef struct packed {
        phase_t  phase;
        result_t result;
    } status_t;

    //--------------------------------------------------------------------
    // random card lanes
    //--------------------------------------------------------------------
    localparam int NUM_LANES = 3;
    localparam int LFSR_W    = 13;
    localparam int LANE_W    = 2;

    // lane 0 seed sits in the low word
    localparam logic [NUM_LANES-1:0][LFSR_W-1:0] LFSR_SEEDS = {
        13'h06a, 13'h0fd, 13'h00a
    };

endpackage
